// File: list.f
+incdir+include
logic/muldiv_pkg.sv
logic/booth_encoder.sv
logic/mul_datapath.sv
logic/div_datapath.sv
logic/muldiv_unit.sv
tb/muldiv_tb.sv

// File: logic/booth_encoder.sv
`timescale 1ns/1ns

module booth_encoder (
   input  logic [2:0]                  window,
   input  logic [muldiv_pkg::xlen-1:0] multiplicand,
   input  logic                        mcand_signed,
   output logic [33:0]                 partial,
   output logic                        negate
);

   logic [33:0] m1; // multiplicand, two sign bits
   logic [33:0] m2; // twice the multiplicand

   assign m1 = {{2{mcand_signed & multiplicand[31]}}, multiplicand};
   assign m2 = {m1[32:0], 1'b0};

   always_comb begin
      partial = '0;
      negate  = 1'b0;
      unique case (window)
         3'b001, 3'b010: partial = m1;
         3'b011: partial = m2;
         3'b100: begin
            partial = ~m2; // +1 comes in at the adder
            negate  = 1'b1;
         end
         3'b101, 3'b110: begin
            partial = ~m1;
            negate  = 1'b1;
         end
         default: partial = '0; // 000 and 111
      endcase
   end

endmodule

// File: logic/div_datapath.sv
`timescale 1ns/1ns

module div_datapath (
   input  logic                        clk,
   input  logic                        start,
   input  logic                        step,
   input  logic [muldiv_pkg::xlen-1:0] in_1,
   input  logic [muldiv_pkg::xlen-1:0] in_2,
   input  logic                        is_signed,
   output logic [muldiv_pkg::xlen-1:0] quotient,
   output logic [muldiv_pkg::xlen-1:0] remainder,
   output logic                        done
);

   import muldiv_pkg::*;

   logic [xlen-1:0] qd;     // dividend bits out at the top, digits in at the bottom
   logic [xlen-1:0] rem;    // partial remainder, always below the divisor
   logic [xlen-1:0] dvs;    // divisor magnitude
   step_cnt_t       cnt;
   logic            q_neg;
   logic            r_neg;
   logic            zero;

   logic [33:0]     shifted;
   logic [33:0]     dvs_2;
   logic [33:0]     dvs_3;
   logic [34:0]     diff_1;
   logic [34:0]     diff_2;
   logic [34:0]     diff_3;
   logic [1:0]      digit;
   logic [xlen-1:0] rem_next;
   logic [xlen-1:0] rem_src;
   logic            running;
   logic            last;

   assign shifted = {rem, qd[xlen-1 -: 2]};
   assign dvs_2   = {1'b0, dvs, 1'b0};
   assign dvs_3   = dvs_2 + {2'b00, dvs};

   // three trial subtractions in parallel
   assign diff_1 = {1'b0, shifted} - {3'b000, dvs};
   assign diff_2 = {1'b0, shifted} - {1'b0, dvs_2};
   assign diff_3 = {1'b0, shifted} - {1'b0, dvs_3};

   always_comb begin
      if (!diff_3[34]) begin
         digit    = 2'd3;
         rem_next = diff_3[xlen-1:0];
      end else if (!diff_2[34]) begin
         digit    = 2'd2;
         rem_next = diff_2[xlen-1:0];
      end else if (!diff_1[34]) begin
         digit    = 2'd1;
         rem_next = diff_1[xlen-1:0];
      end else begin
         digit    = 2'd0;
         rem_next = shifted[xlen-1:0];
      end
   end

   assign last    = (cnt == step_cnt_t'(div_steps));
   assign running = step & ~zero & ~last;

   always_ff @(posedge clk) begin
      if (start) begin
         qd    <= (is_signed & in_1[xlen-1]) ? -in_1 : in_1;
         dvs   <= (is_signed & in_2[xlen-1]) ? -in_2 : in_2;
         rem   <= '0;
         cnt   <= '0;
         q_neg <= is_signed & (in_1[xlen-1] ^ in_2[xlen-1]);
         r_neg <= is_signed & in_1[xlen-1];
         zero  <= (in_2 == '0);
      end else if (running) begin
         qd  <= {qd[xlen-3:0], digit};
         rem <= rem_next;
         cnt <= cnt + 1'b1;
      end
   end

   // fix-up cycle, the top captures these on the edge that ends it
   assign done = step & (zero | last);

   // zero divisor: qd still holds the dividend magnitude
   assign rem_src   = zero ? qd : rem;
   assign quotient  = zero ? '1 : (q_neg ? -qd : qd);
   assign remainder = r_neg ? -rem_src : rem_src;

endmodule

// File: logic/mul_datapath.sv
`timescale 1ns/1ns

module mul_datapath (
   input  logic                        clk,
   input  logic                        start,
   input  logic                        step,
   input  logic [muldiv_pkg::xlen-1:0] in_1,
   input  logic [muldiv_pkg::xlen-1:0] in_2,
   input  logic                        in_1_signed,
   input  logic                        in_2_signed,
   output logic [muldiv_pkg::xlen-1:0] prod_hi,
   output logic [muldiv_pkg::xlen-1:0] prod_lo
);

   import muldiv_pkg::*;

   localparam int acc_w = 42; // running sum width, holds one byte step

   logic [xlen-1:0]         mult;         // multiplier, shifts right
   logic                    prev;         // bit below the current byte
   logic                    mult_signed;
   logic [xlen-1:0]         mcand;
   logic                    mcand_signed;
   logic                    top_fix;      // unsigned multiplier with msb set
   logic signed [acc_w-1:0] hi;
   logic [xlen-1:0]         lo;

   logic [2:0]       win  [4];
   logic [33:0]      part [4];
   logic [3:0]       neg;
   logic [acc_w-1:0] ext  [4];
   logic [acc_w-1:0] csa_sum;
   logic [acc_w-1:0] csa_cry;
   logic [acc_w-1:0] neg_bits;
   logic signed [acc_w-1:0] t;

   for (genvar k = 0; k < 4; k++) begin : g_booth
      if (k == 0) begin : g_first
         assign win[k] = {mult[1:0], prev};
      end else begin : g_next
         assign win[k] = mult[2*k+1 -: 3];
      end

      booth_encoder booth_encoder_inst (
         .window       (win[k]),
         .multiplicand (mcand),
         .mcand_signed (mcand_signed),
         .partial      (part[k]),
         .negate       (neg[k])
      );

      assign ext[k] = {{(acc_w-34){part[k][33]}}, part[k]};
   end

   // 3:2 row over the first three weighted rows
   assign csa_sum = ext[0] ^ (ext[1] << 2) ^ (ext[2] << 4);
   assign csa_cry = (ext[0] & (ext[1] << 2)) | ((ext[1] << 2) & (ext[2] << 4)) |
                    (ext[0] & (ext[2] << 4));

   assign neg_bits = {{(acc_w-7){1'b0}}, neg[3], 1'b0, neg[2], 1'b0, neg[1], 1'b0, neg[0]};

   // final adder, also folds in the running high part
   assign t = hi + csa_sum + (csa_cry << 1) + (ext[3] << 6) + neg_bits;

   always_ff @(posedge clk) begin
      if (start) begin
         mult         <= in_1;
         prev         <= 1'b0;
         mult_signed  <= in_1_signed;
         mcand        <= in_2;
         mcand_signed <= in_2_signed;
         top_fix      <= in_1[xlen-1] & ~in_1_signed;
         hi           <= '0;
         lo           <= '0;
      end else if (step) begin
         prev <= mult[7];
         mult <= {{8{mult_signed & mult[xlen-1]}}, mult[xlen-1:8]};
         hi   <= t >>> 8;
         lo   <= {t[7:0], lo[xlen-1:8]};
      end
   end

   // booth windows see in_1 as signed, add back 2^32 * in_2 when it was not
   assign prod_hi = (step ? t[xlen+7:8] : hi[xlen-1:0]) + (top_fix ? mcand : '0);
   assign prod_lo = step ? {t[7:0], lo[xlen-1:8]} : lo; // value after the step in flight

endmodule

// File: logic/muldiv_pkg.sv
package muldiv_pkg;

   // operation class of a request
   typedef enum logic {
      md_op_mul = 1'b0,
      md_op_div = 1'b1
   } md_op_t;

   // lo is product low word or quotient, hi is product high word or remainder
   typedef enum logic {
      md_out_lo = 1'b0,
      md_out_hi = 1'b1
   } md_out_t;

   localparam int xlen = 32;      // operand width
   localparam int mul_steps = 4;  // eight multiplier bits per step
   localparam int div_steps = 16; // two quotient bits per step

   typedef logic [4:0] step_cnt_t;

endpackage

// File: logic/muldiv_unit.sv
`timescale 1ns/1ns

module muldiv_unit (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        req_valid,
   output logic                        req_ready,
   input  muldiv_pkg::md_op_t          req_op,
   input  muldiv_pkg::md_out_t         req_out_sel,
   input  logic                        req_in_1_signed,
   input  logic                        req_in_2_signed,
   input  logic [muldiv_pkg::xlen-1:0] req_in_1,
   input  logic [muldiv_pkg::xlen-1:0] req_in_2,
   output logic                        resp_valid,
   output logic [muldiv_pkg::xlen-1:0] resp_result
);

   import muldiv_pkg::*;

   logic      busy;
   md_op_t    op;
   md_out_t   out_sel;
   step_cnt_t cnt;

   logic            accept;
   logic            mul_start;
   logic            div_start;
   logic            mul_step;
   logic            div_step;
   logic            mul_done;
   logic            div_done;
   logic            finish;
   logic [xlen-1:0] prod_hi;
   logic [xlen-1:0] prod_lo;
   logic [xlen-1:0] quotient;
   logic [xlen-1:0] remainder;
   logic [xlen-1:0] result;

   assign req_ready = ~busy;
   assign accept    = req_valid & ~busy;
   assign mul_start = accept & (req_op == md_op_mul);
   assign div_start = accept & (req_op == md_op_div);
   assign mul_step  = busy & (op == md_op_mul);
   assign div_step  = busy & (op == md_op_div);
   assign mul_done  = mul_step & (cnt == step_cnt_t'(mul_steps - 1)); // 4th step edge
   assign finish    = mul_done | div_done;

   mul_datapath mul_datapath_inst (
      .clk         (clk),
      .start       (mul_start),
      .step        (mul_step),
      .in_1        (req_in_1),
      .in_2        (req_in_2),
      .in_1_signed (req_in_1_signed),
      .in_2_signed (req_in_2_signed),
      .prod_hi     (prod_hi),
      .prod_lo     (prod_lo)
   );

   div_datapath div_datapath_inst (
      .clk       (clk),
      .start     (div_start),
      .step      (div_step),
      .in_1      (req_in_1),
      .in_2      (req_in_2),
      .is_signed (req_in_1_signed),
      .quotient  (quotient),
      .remainder (remainder),
      .done      (div_done)
   );

   always_comb begin
      if (op == md_op_mul)
         result = (out_sel == md_out_hi) ? prod_hi : prod_lo;
      else
         result = (out_sel == md_out_hi) ? remainder : quotient;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy       <= 1'b0;
         op         <= md_op_mul;
         out_sel    <= md_out_lo;
         cnt        <= '0;
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= finish; // single cycle pulse
         if (accept) begin
            busy    <= 1'b1;
            op      <= req_op;
            out_sel <= req_out_sel;
            cnt     <= '0;
         end else if (finish) begin
            busy <= 1'b0;
            cnt  <= '0;
         end else if (busy) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // held until the next response
   always_ff @(posedge clk) begin
      if (finish)
         resp_result <= result;
   end

endmodule

// File: run.sh
#!/bin/sh
# build and run the muldiv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module muldiv_tb -f list.f -o muldiv_sim

out=$(./obj_dir/muldiv_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
   exit 0
fi
echo "simulation failed"
exit 1

// File: include/muldiv_vectors.svh
`ifndef MULDIV_VECTORS_SVH
`define MULDIV_VECTORS_SVH

// one directed test, name is up to 12 characters
typedef struct packed {
   logic [95:0]         name;
   muldiv_pkg::md_op_t  op;
   muldiv_pkg::md_out_t out_sel;
   logic                in_1_signed;
   logic                in_2_signed;
   logic [31:0]         in_1;
   logic [31:0]         in_2;
   logic [31:0]         expected;
} md_vec_t;

localparam int md_vector_count = 22;

localparam md_vec_t md_vectors [0:md_vector_count-1] = '{
   '{"mul_small",   muldiv_pkg::md_op_mul, muldiv_pkg::md_out_lo, 1'b1, 1'b1,
     32'h00000007, 32'h00000006, 32'h0000002a},
   '{"mul_neg",     muldiv_pkg::md_op_mul, muldiv_pkg::md_out_lo, 1'b1, 1'b1,
     32'hfffffffd, 32'h00000005, 32'hfffffff1},
   '{"mulh_m1m1",   muldiv_pkg::md_op_mul, muldiv_pkg::md_out_hi, 1'b1, 1'b1,
     32'hffffffff, 32'hffffffff, 32'h00000000},
   '{"mulh_minmin", muldiv_pkg::md_op_mul, muldiv_pkg::md_out_hi, 1'b1, 1'b1,
     32'h80000000, 32'h80000000, 32'h40000000},
   '{"mulhu_max",   muldiv_pkg::md_op_mul, muldiv_pkg::md_out_hi, 1'b0, 1'b0,
     32'hffffffff, 32'hffffffff, 32'hfffffffe},
   '{"mulhsu_m1",   muldiv_pkg::md_op_mul, muldiv_pkg::md_out_hi, 1'b1, 1'b0,
     32'hffffffff, 32'hffffffff, 32'hffffffff},
   '{"mulhu_2p32",  muldiv_pkg::md_op_mul, muldiv_pkg::md_out_hi, 1'b0, 1'b0,
     32'h80000000, 32'h00000002, 32'h00000001},
   '{"mul_min_m1",  muldiv_pkg::md_op_mul, muldiv_pkg::md_out_lo, 1'b1, 1'b1,
     32'h80000000, 32'hffffffff, 32'h80000000},
   '{"mulh_minmax", muldiv_pkg::md_op_mul, muldiv_pkg::md_out_hi, 1'b1, 1'b1,
     32'h80000000, 32'h7fffffff, 32'hc0000000},
   '{"mulhsu_min",  muldiv_pkg::md_op_mul, muldiv_pkg::md_out_hi, 1'b1, 1'b0,
     32'h80000000, 32'h80000000, 32'hc0000000},
   '{"div_pos",     muldiv_pkg::md_op_div, muldiv_pkg::md_out_lo, 1'b1, 1'b1,
     32'h00000014, 32'h00000003, 32'h00000006},
   '{"div_neg",     muldiv_pkg::md_op_div, muldiv_pkg::md_out_lo, 1'b1, 1'b1,
     32'hffffffec, 32'h00000003, 32'hfffffffa},
   '{"rem_neg",     muldiv_pkg::md_op_div, muldiv_pkg::md_out_hi, 1'b1, 1'b1,
     32'hffffffec, 32'h00000003, 32'hfffffffe},
   '{"rem_negdvs",  muldiv_pkg::md_op_div, muldiv_pkg::md_out_hi, 1'b1, 1'b1,
     32'h00000014, 32'hfffffffd, 32'h00000002},
   '{"divu_by1",    muldiv_pkg::md_op_div, muldiv_pkg::md_out_lo, 1'b0, 1'b0,
     32'hffffffff, 32'h00000001, 32'hffffffff},
   '{"remu_small",  muldiv_pkg::md_op_div, muldiv_pkg::md_out_hi, 1'b0, 1'b0,
     32'h00000064, 32'h00000007, 32'h00000002},
   '{"div_zero",    muldiv_pkg::md_op_div, muldiv_pkg::md_out_lo, 1'b1, 1'b1,
     32'h00001234, 32'h00000000, 32'hffffffff},
   '{"remu_zero",   muldiv_pkg::md_op_div, muldiv_pkg::md_out_hi, 1'b0, 1'b0,
     32'hdeadbeef, 32'h00000000, 32'hdeadbeef},
   '{"div_ovf",     muldiv_pkg::md_op_div, muldiv_pkg::md_out_lo, 1'b1, 1'b1,
     32'h80000000, 32'hffffffff, 32'h80000000},
   '{"rem_ovf",     muldiv_pkg::md_op_div, muldiv_pkg::md_out_hi, 1'b1, 1'b1,
     32'h80000000, 32'hffffffff, 32'h00000000},
   '{"div_by1_neg", muldiv_pkg::md_op_div, muldiv_pkg::md_out_lo, 1'b1, 1'b1,
     32'hfffffff9, 32'h00000001, 32'hfffffff9},
   '{"divu_big",    muldiv_pkg::md_op_div, muldiv_pkg::md_out_lo, 1'b0, 1'b0,
     32'h80000000, 32'hffffffff, 32'h00000000}
};

`endif

// File: tb/muldiv_tb.sv
`timescale 1ns/1ns

module muldiv_tb;

   import muldiv_pkg::*;

`include "muldiv_vectors.svh"

   localparam int clk_period      = 100;
   localparam int random_count    = 200;
   localparam int watchdog_cycles = (md_vector_count + random_count) * 25;

   logic            clk;
   logic            reset;
   logic            req_valid;
   logic            req_ready;
   md_op_t          req_op;
   md_out_t         req_out_sel;
   logic            req_in_1_signed;
   logic            req_in_2_signed;
   logic [xlen-1:0] req_in_1;
   logic [xlen-1:0] req_in_2;
   logic            resp_valid;
   logic [xlen-1:0] resp_result;

   logic [31:0] rng;
   logic [31:0] last_result; // expected value of the previous response
   logic        have_result;

   muldiv_unit muldiv_unit_inst (
      .clk             (clk),
      .reset           (reset),
      .req_valid       (req_valid),
      .req_ready       (req_ready),
      .req_op          (req_op),
      .req_out_sel     (req_out_sel),
      .req_in_1_signed (req_in_1_signed),
      .req_in_2_signed (req_in_2_signed),
      .req_in_1        (req_in_1),
      .req_in_2        (req_in_2),
      .resp_valid      (resp_valid),
      .resp_result     (resp_result)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
         stop_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // corner values show up often
   function automatic logic [31:0] pick_operand(input logic [2:0] sel, input logic [31:0] word);
      case (sel)
         3'd0: return 32'h00000000;
         3'd1: return 32'h00000001;
         3'd2: return 32'hffffffff;
         3'd3: return 32'h80000000;
         3'd4: return {28'h0, word[3:0]};
         default: return word;
      endcase
   endfunction

   function automatic string to_text(input logic [95:0] packed_name);
      string s;
      s = "";
      for (int i = 11; i >= 0; i--) begin
         if (packed_name[i*8 +: 8] != 8'h00)
            s = {s, $sformatf("%c", packed_name[i*8 +: 8])};
      end
      return s;
   endfunction

   function automatic logic [31:0] model_result(input md_op_t op, input md_out_t out_sel,
                                                input logic s1, input logic s2,
                                                input logic [31:0] a, input logic [31:0] b);
      logic [63:0] ea;
      logic [63:0] eb;
      logic [63:0] prod;
      logic [31:0] ma;
      logic [31:0] mb;
      logic [31:0] q;
      logic [31:0] r;
      ea   = s1 ? {{32{a[31]}}, a} : {32'h0, a};
      eb   = s2 ? {{32{b[31]}}, b} : {32'h0, b};
      prod = ea * eb; // low 64 bits hold for any sign mix
      if (op == md_op_mul)
         return (out_sel == md_out_hi) ? prod[63:32] : prod[31:0];
      if (b == 32'h0) begin
         q = 32'hffffffff;
         r = a;
      end else if (s1 && a == 32'h80000000 && b == 32'hffffffff) begin
         q = a;
         r = 32'h0;
      end else if (s1) begin
         ma = a[31] ? -a : a;
         mb = b[31] ? -b : b;
         q  = ma / mb;
         r  = ma % mb;
         if (a[31] != b[31])
            q = -q; // truncate toward zero
         if (a[31])
            r = -r;
      end else begin
         q = a / b;
         r = a % b;
      end
      return (out_sel == md_out_hi) ? r : q;
   endfunction

   // edges from acceptance to the response, accepting edge counted
   function automatic int expected_edges(input md_op_t op, input logic [31:0] b);
      if (op == md_op_mul)
         return 5;
      if (b == 32'h0)
         return 2;
      return 18;
   endfunction

   task automatic run_request(input string name, input md_op_t op, input md_out_t out_sel,
                              input logic s1, input logic s2, input logic [31:0] a,
                              input logic [31:0] b, input logic [31:0] expected,
                              input logic hold);
      int edges;
      int want;
      want = expected_edges(op, b);
      @(negedge clk);
      check_value({name, " idle ready"}, 32'd1, {31'd0, req_ready});
      if (have_result)
         check_value({name, " result held idle"}, last_result, resp_result);
      @(posedge clk);
      req_valid       <= 1'b1;
      req_op          <= op;
      req_out_sel     <= out_sel;
      req_in_1_signed <= s1;
      req_in_2_signed <= s2;
      req_in_1        <= a;
      req_in_2        <= b;
      @(posedge clk); // accepting edge
      edges = 1;
      if (!hold)
         req_valid <= 1'b0;
      @(negedge clk);
      while (resp_valid !== 1'b1) begin
         check_value({name, " busy ready"}, 32'd0, {31'd0, req_ready});
         if (have_result)
            check_value({name, " old result"}, last_result, resp_result);
         if (edges > 40)
            stop_run($sformatf("%s: no response from the DUT after %0d cycles", name, edges));
         @(posedge clk);
         edges++;
         if (hold && edges == want)
            req_valid <= 1'b0; // low again before the unit goes idle
         @(negedge clk);
      end
      check_value({name, " latency"}, want, edges);
      check_value({name, " ready at response"}, 32'd1, {31'd0, req_ready});
      check_value(name, expected, resp_result);
      @(negedge clk);
      check_value({name, " single pulse"}, 32'd0, {31'd0, resp_valid});
      check_value({name, " result held"}, expected, resp_result);
      check_value({name, " no second accept"}, 32'd1, {31'd0, req_ready});
      last_result = expected;
      have_result = 1'b1;
   endtask

   initial begin
      #(watchdog_cycles * clk_period);
      stop_run($sformatf("watchdog: the run did not finish within %0d cycles", watchdog_cycles));
   end

   initial begin
      md_vec_t     v;
      md_op_t      op;
      md_out_t     out_sel;
      logic        s1;
      logic        s2;
      logic        hold;
      logic [2:0]  sel;
      logic [31:0] a;
      logic [31:0] b;
      rng             = 32'hb1d3f929;
      last_result     = '0;
      have_result     = 1'b0;
      reset           = 1'b1;
      req_valid       = 1'b0;
      req_op          = md_op_mul;
      req_out_sel     = md_out_lo;
      req_in_1_signed = 1'b0;
      req_in_2_signed = 1'b0;
      req_in_1        = '0;
      req_in_2        = '0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("reset req_ready", 32'd1, {31'd0, req_ready});
      check_value("reset resp_valid", 32'd0, {31'd0, resp_valid});

      for (int i = 0; i < md_vector_count; i++) begin
         v = md_vectors[i];
         check_value({to_text(v.name), " table row"},
                     model_result(v.op, v.out_sel, v.in_1_signed, v.in_2_signed, v.in_1, v.in_2),
                     v.expected);
         run_request(to_text(v.name), v.op, v.out_sel, v.in_1_signed, v.in_2_signed,
                     v.in_1, v.in_2, v.expected, i[0]); // odd rows hold req_valid
      end

      for (int n = 0; n < random_count; n++) begin
         rng     = xorshift32(rng);
         op      = md_op_t'(rng[0]);
         out_sel = md_out_t'(rng[1]);
         s1      = rng[2];
         s2      = (op == md_op_div) ? rng[2] : (rng[2] & rng[3]); // mulhsu but not mulhus
         hold    = rng[4];
         sel     = rng[7:5];
         rng     = xorshift32(rng);
         a       = pick_operand(sel, rng);
         rng     = xorshift32(rng);
         sel     = rng[2:0];
         rng     = xorshift32(rng);
         b       = pick_operand(sel, rng);
         run_request($sformatf("random %0d", n), op, out_sel, s1, s2, a, b,
                     model_result(op, out_sel, s1, s2, a, b), hold);
      end

      $display("** PASS **");
      $finish;
   end

endmodule
